// File: common/videoPkg.sv
////////////////////
// Shared definitions for the raster video subsystem.
// Timing constants, video RAM geometry, arbiter slot owner and packed structs.
////////////////////

package videoPkg;

    // Line geometry in pixel clocks.
    localparam int hTotal      = 512;
    localparam int hBlankStart = 448;
    localparam int hBlankEnd   = 64;
    localparam int hSyncStart  = 'h1DC;

    // Frame geometry in lines.
    localparam int vTotal        = 262;
    localparam int vVisibleStart = 14;
    localparam int vVisibleEnd   = 237;
    localparam int vSyncStart    = 'h100;
    localparam int vSyncEnd      = 1;

    // Bitmap layout, 4 pixels per 16-bit word.
    localparam int lineWords    = 96;
    localparam int rowStride    = 128;
    localparam int vramAddrBits = 15;
    localparam int pixelBits    = 4;

    // Owner of the current video RAM cycle.
    typedef enum logic {
        slotFetch,
        slotHost
    } vramSlot_e;

    // Request presented by a peer to the arbiter.
    typedef struct packed {
        logic [vramAddrBits-1:0] addr;
        logic [15:0]             data;
        logic                    write;
    } vramReq_t;

    // Raster position as seen by the fetcher and the playback stage.
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;
        logic       hBlank;
        logic       vBlank;
        logic       lineStart;
    } rasterPos_t;

endpackage

// File: timing/videoTiming.sv
////////////////////
// Video timing generator, 512 pixels by 262 lines, one step per cen8.
// Drives the raster position bundle plus the sync outputs.
////////////////////

`timescale 1ns/1ps

module videoTiming (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen8,
    output videoPkg::rasterPos_t raster,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 preVBlank
);

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic [8:0] vrender;
    logic [8:0] vrender1;
    logic       hBlank;
    logic       vBlank;
    logic       lineStart;
    // Vertical blank shift, one stage per line.
    logic [1:0] shVBlank;

    assign preVBlank = shVBlank[0];

    assign raster.hdump     = hdump;
    assign raster.vdump     = vdump;
    assign raster.vrender   = vrender;
    assign raster.hBlank    = hBlank;
    assign raster.vBlank    = vBlank;
    assign raster.lineStart = lineStart;

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump     <= 9'd0;
            vdump     <= 9'(videoPkg::vTotal - 1);
            vrender   <= 9'd0;
            vrender1  <= 9'd0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hBlank    <= 1'b1;
            vBlank    <= 1'b1;
            shVBlank  <= 2'b00;
            lineStart <= 1'b1;
        end else if (cen8) begin
            hdump       <= hdump + 9'd1;
            // Blanks are registered from the old counters.
            shVBlank[0] <= vdump < videoPkg::vVisibleStart || vdump > videoPkg::vVisibleEnd;
            hBlank      <= hdump >= videoPkg::hBlankStart || hdump < videoPkg::hBlankEnd;
            if (hdump == videoPkg::hSyncStart) begin
                hsync <= 1'b1;
                // Vertical sync only moves on the hsync rising edge.
                if (vdump == videoPkg::vSyncStart) vsync <= 1'b1;
                if (vdump == videoPkg::vSyncEnd) vsync <= 1'b0;
            end
            if (hdump == 9'd0) hsync <= 1'b0;
            lineStart <= &hdump;
            if (&hdump) begin
                hdump    <= 9'd0;
                // Render line runs one line ahead of display.
                vrender1 <= (vrender1 == videoPkg::vTotal - 1) ? 9'd0 : vrender1 + 9'd1;
                vrender  <= vrender1;
                vdump    <= vrender;
                {vBlank, shVBlank[1]} <= shVBlank;
            end
        end
    end

    // Counters stay within the frame.
    assert property (@(posedge clk) disable iff (reset)
        hdump <= 9'(videoPkg::hTotal - 1) && vdump <= 9'(videoPkg::vTotal - 1));

    // vsync edges are locked to hsync rising edges.
    assert property (@(posedge clk) disable iff (reset)
        $changed(vsync) |-> $rose(hsync));

endmodule

// File: logic/vramArbiter.sv
////////////////////
// Video RAM with time-slot arbitration between the fetcher and the host.
// Even cen8 slots belong to the fetcher, odd ones to the host.
////////////////////

`timescale 1ns/1ps

module vramArbiter (
    input  logic                clk,
    input  logic                cen8,
    input  videoPkg::vramReq_t  fetchReq,
    input  videoPkg::vramReq_t  hostReq,
    input  logic                hdumpOdd,
    output videoPkg::vramSlot_e slot,
    output logic [15:0]         readData,
    output logic                hostReady
);

    // 32K words of bitmap storage.
    logic [15:0] mem [0:(2**videoPkg::vramAddrBits)-1];

    // Request of the current slot owner.
    videoPkg::vramReq_t activeReq;

    // Slot owner follows the parity of hdump.
    always_comb begin
        slot = hdumpOdd ? videoPkg::slotHost : videoPkg::slotFetch;
    end

    // Host may write only inside its own cen8 cycle.
    assign hostReady = cen8 && hdumpOdd;

    always_comb begin
        if (slot == videoPkg::slotHost) begin
            activeReq = hostReq;
        end else begin
            activeReq = fetchReq;
        end
    end

    // One access per cen8 cycle.
    // Read data shows up one clock after the slot.
    always_ff @(posedge clk) begin
        if (cen8) begin
            if (activeReq.write) begin
                mem[activeReq.addr] <= activeReq.data;
            end
            readData <= mem[activeReq.addr];
        end
    end

    // Fetcher is read-only.
    assert property (@(posedge clk) !fetchReq.write);

endmodule

// File: render/scanlineFetch.sv
////////////////////
// Fetches the 96 bitmap words of the render line into the line buffer.
// Words are read on the fetch slots and written one clock later.
////////////////////

`timescale 1ns/1ps

module scanlineFetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen8,
    input  videoPkg::rasterPos_t raster,
    input  videoPkg::vramSlot_e slot,
    input  logic [15:0]         readData,
    output videoPkg::vramReq_t  fetchReq,
    output logic                bufWrite,
    output logic                bufHalf,
    output logic [6:0]          bufWord,
    output logic [15:0]         bufData
);

    typedef enum logic {
        fetchIdle,
        fetchActive
    } fetchState_e;

    fetchState_e state;
    logic [6:0]  wordIdx;
    logic        rowVisible;
    logic [8:0]  rowFull;
    logic        issue;
    // Word in flight, paired with its index.
    logic        pendValid;
    logic [6:0]  pendWord;
    logic        pendHalf;

    assign rowVisible = raster.vrender >= videoPkg::vVisibleStart
                     && raster.vrender <= videoPkg::vVisibleEnd;
    assign rowFull = raster.vrender - 9'(videoPkg::vVisibleStart);

    // Word 0 goes out on the lineStart cycle itself.
    assign issue = cen8 && slot == videoPkg::slotFetch
                && (state == fetchActive || (raster.lineStart && rowVisible));

    always_comb begin
        fetchReq.addr  = videoPkg::vramAddrBits'(int'(rowFull[7:0]) * videoPkg::rowStride
                                                 + int'(wordIdx));
        fetchReq.data  = 16'd0;
        fetchReq.write = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetchIdle;
            wordIdx <= 7'd0;
        end else if (issue) begin
            if (wordIdx == 7'(videoPkg::lineWords - 1)) begin
                state   <= fetchIdle;
                wordIdx <= 7'd0;
            end else begin
                state   <= fetchActive;
                wordIdx <= wordIdx + 7'd1;
            end
        end
    end

    // Returning word lands in half vrender[0].
    always_ff @(posedge clk) begin
        if (reset) begin
            pendValid <= 1'b0;
        end else begin
            pendValid <= issue;
        end
        pendWord <= wordIdx;
        pendHalf <= raster.vrender[0];
    end

    assign bufWrite = pendValid;
    assign bufHalf  = pendHalf;
    assign bufWord  = pendWord;
    assign bufData  = readData;

endmodule

// File: render/linePlayback.sv
////////////////////
// Double line buffer and pixel output stage.
// Display reads half vdump[0] while the fetcher fills the other.
////////////////////

`timescale 1ns/1ps

module linePlayback (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cen8,
    input  videoPkg::rasterPos_t            raster,
    input  logic                            bufWrite,
    input  logic                            bufHalf,
    input  logic [6:0]                      bufWord,
    input  logic [15:0]                     bufData,
    output logic [videoPkg::pixelBits-1:0]  pixel
);

    // Two line stores of 96 words each.
    logic [15:0] lineStore [0:1][0:videoPkg::lineWords-1];

    logic [8:0]  col;
    logic [6:0]  colWord;
    logic [1:0]  colNibble;
    logic [15:0] readWord;
    logic        blankNow;

    // Column relative to the first active pixel.
    assign col       = raster.hdump - 9'(videoPkg::hBlankEnd);
    assign colWord   = col[8:2];
    assign colNibble = col[1:0];
    assign readWord  = lineStore[raster.vdump[0]][colWord];
    assign blankNow  = raster.hdump >= videoPkg::hBlankStart
                    || raster.hdump < videoPkg::hBlankEnd
                    || raster.vBlank;

    always_ff @(posedge clk) begin
        if (bufWrite) begin
            lineStore[bufHalf][bufWord] <= bufData;
        end
    end

    // Nibble 0 is the leftmost pixel of a word.
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel <= '0;
        end else if (cen8) begin
            pixel <= blankNow ? '0
                              : readWord[colNibble*videoPkg::pixelBits +: videoPkg::pixelBits];
        end
    end

    // Fetcher never writes the half on screen.
    assert property (@(posedge clk) disable iff (reset)
        bufWrite && !raster.hBlank && !raster.vBlank |-> bufHalf != raster.vdump[0]);

endmodule

// File: logic/videoTop.sv
////////////////////
// Top level of the raster video subsystem.
// Wires timing, video RAM arbiter, fetcher and playback to the pins.
////////////////////

`timescale 1ns/1ps

module videoTop (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cen8,
    input  logic                              hostWrite,
    input  logic [videoPkg::vramAddrBits-1:0] hostAddr,
    input  logic [15:0]                       hostData,
    output logic                              hostReady,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              hBlank,
    output logic                              vBlank,
    output logic                              preVBlank,
    output logic [videoPkg::pixelBits-1:0]    pixel
);

    videoPkg::rasterPos_t raster;
    videoPkg::vramReq_t   fetchReq;
    videoPkg::vramReq_t   hostReq;
    videoPkg::vramSlot_e  slot;
    logic [15:0]          readData;
    logic                 bufWrite;
    logic                 bufHalf;
    logic [6:0]           bufWord;
    logic [15:0]          bufData;

    // Host pins packed into a request.
    assign hostReq = '{addr: hostAddr, data: hostData, write: hostWrite};

    assign hBlank = raster.hBlank;
    assign vBlank = raster.vBlank;

    videoTiming timing (
        .clk      (clk),
        .reset    (reset),
        .cen8     (cen8),
        .raster   (raster),
        .hsync    (hsync),
        .vsync    (vsync),
        .preVBlank(preVBlank)
    );

    vramArbiter arbiter (
        .clk      (clk),
        .cen8     (cen8),
        .fetchReq (fetchReq),
        .hostReq  (hostReq),
        .hdumpOdd (raster.hdump[0]),
        .slot     (slot),
        .readData (readData),
        .hostReady(hostReady)
    );

    scanlineFetch fetch (
        .clk     (clk),
        .reset   (reset),
        .cen8    (cen8),
        .raster  (raster),
        .slot    (slot),
        .readData(readData),
        .fetchReq(fetchReq),
        .bufWrite(bufWrite),
        .bufHalf (bufHalf),
        .bufWord (bufWord),
        .bufData (bufData)
    );

    linePlayback playback (
        .clk     (clk),
        .reset   (reset),
        .cen8    (cen8),
        .raster  (raster),
        .bufWrite(bufWrite),
        .bufHalf (bufHalf),
        .bufWord (bufWord),
        .bufData (bufData),
        .pixel   (pixel)
    );

endmodule

// File: test/clockGen.sv
////////////////////
// Testbench clock with a 40 ns period.
// Reset is held high for the first 16 cycles.
////////////////////

`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset drops on a rising edge, like the rest of the stimulus.
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: test/videoTopTb.sv
////////////////////
// Testbench for the raster video subsystem.
// Random host writes from a fixed seed, checked against a timing and pixel model.
////////////////////

`timescale 1ns/1ps

module videoTopTb;

    logic                              clk;
    logic                              reset;
    logic                              cen8;
    logic                              hostWrite;
    logic [videoPkg::vramAddrBits-1:0] hostAddr;
    logic [15:0]                       hostData;
    logic                              hostReady;
    logic                              hsync;
    logic                              vsync;
    logic                              hBlank;
    logic                              vBlank;
    logic                              preVBlank;
    logic [videoPkg::pixelBits-1:0]    pixel;

    // Model state as it stands after the latest clock edge.
    int         mHdump;
    int         mVdump;
    int         mVrender;
    int         mVrender1;
    int         mWordIdx;
    logic       mHsync;
    logic       mVsync;
    logic       mHblank;
    logic       mVblank;
    logic       mSh0;
    logic       mSh1;
    logic       mLineStart;
    logic       mFetching;
    logic [3:0] mPixel;
    logic       mPixelKnown;
    logic       modelInReset;

    // Model video RAM and line buffers, with a flag for words holding real data.
    logic [15:0] ramModel [0:(2**videoPkg::vramAddrBits)-1];
    logic        ramKnown [0:(2**videoPkg::vramAddrBits)-1];
    logic [15:0] bufModel [0:1][0:videoPkg::lineWords-1];
    logic        bufKnown [0:1][0:videoPkg::lineWords-1];

    // 0 idle, 1 sequential fill, 2 random writes.
    int   writeMode;
    int   fillIndex;
    int   fillWords;
    int   frameClocks;
    int   activeChecks;
    int   vsyncRises;
    int   raceWrites;
    logic prevVsync;

    clockGen clocks (
        .clk  (clk),
        .reset(reset)
    );

    videoTop dut (
        .clk      (clk),
        .reset    (reset),
        .cen8     (cen8),
        .hostWrite(hostWrite),
        .hostAddr (hostAddr),
        .hostData (hostData),
        .hostReady(hostReady),
        .hsync    (hsync),
        .vsync    (vsync),
        .hBlank   (hBlank),
        .vBlank   (vBlank),
        .preVBlank(preVBlank),
        .pixel    (pixel)
    );

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // State right after a reset edge.
    task automatic resetModel();
        mHdump      = 0;
        mVdump      = videoPkg::vTotal - 1;
        mVrender    = 0;
        mVrender1   = 0;
        mWordIdx    = 0;
        mHsync      = 1'b0;
        mVsync      = 1'b0;
        mHblank     = 1'b1;
        mVblank     = 1'b1;
        mSh0        = 1'b0;
        mSh1        = 1'b0;
        mLineStart  = 1'b1;
        mFetching   = 1'b0;
        mPixel      = 4'd0;
        mPixelKnown = 1'b1;
    endtask

    // Predicts the next clock edge from the pins now applied.
    task automatic advanceModel();
        int          nh;
        int          nv;
        int          nvr;
        int          nvr1;
        int          col;
        int          half;
        int          addr;
        logic [15:0] word16;
        logic        nhs;
        logic        nvs;
        logic        nsh1;
        logic        nvb;
        modelInReset = reset;
        if (reset) begin
            resetModel();
        end else if (cen8) begin
            // Pixel comes from the old position and the old buffer contents.
            if (mHdump >= videoPkg::hBlankStart || mHdump < videoPkg::hBlankEnd || mVblank) begin
                mPixel      = 4'd0;
                mPixelKnown = 1'b1;
            end else begin
                col         = mHdump - videoPkg::hBlankEnd;
                half        = mVdump % 2;
                word16      = bufModel[half][col / 4];
                mPixel      = word16[(col % 4) * 4 +: 4];
                mPixelKnown = bufKnown[half][col / 4];
            end
            // Fetch slot on even hdump.
            if (mHdump % 2 == 0 && (mFetching || (mLineStart
                    && mVrender >= videoPkg::vVisibleStart
                    && mVrender <= videoPkg::vVisibleEnd))) begin
                addr = (mVrender - videoPkg::vVisibleStart) * videoPkg::rowStride + mWordIdx;
                bufModel[mVrender % 2][mWordIdx] = ramModel[addr];
                bufKnown[mVrender % 2][mWordIdx] = ramKnown[addr];
                mFetching = mWordIdx != videoPkg::lineWords - 1;
                mWordIdx  = mFetching ? mWordIdx + 1 : 0;
            end
            // Host slot on odd hdump.
            if (mHdump % 2 == 1 && hostWrite) begin
                ramModel[hostAddr] = hostData;
                ramKnown[hostAddr] = 1'b1;
            end
            nh   = mHdump + 1;
            nv   = mVdump;
            nvr  = mVrender;
            nvr1 = mVrender1;
            nvb  = mVblank;
            nsh1 = mSh1;
            nhs  = mHsync;
            nvs  = mVsync;
            if (mHdump == videoPkg::hSyncStart) begin
                nhs = 1'b1;
                if (mVdump == videoPkg::vSyncStart) nvs = 1'b1;
                if (mVdump == videoPkg::vSyncEnd) nvs = 1'b0;
            end
            if (mHdump == 0) nhs = 1'b0;
            // Line wrap moves the vertical counters and the blank shift.
            if (mHdump == videoPkg::hTotal - 1) begin
                nh   = 0;
                nvr1 = (mVrender1 == videoPkg::vTotal - 1) ? 0 : mVrender1 + 1;
                nvr  = mVrender1;
                nv   = mVrender;
                nvb  = mSh1;
                nsh1 = mSh0;
            end
            mSh0       = mVdump < videoPkg::vVisibleStart || mVdump > videoPkg::vVisibleEnd;
            mHblank    = mHdump >= videoPkg::hBlankStart || mHdump < videoPkg::hBlankEnd;
            mLineStart = mHdump == videoPkg::hTotal - 1;
            mHdump     = nh;
            mVdump     = nv;
            mVrender   = nvr;
            mVrender1  = nvr1;
            mVblank    = nvb;
            mSh1       = nsh1;
            mHsync     = nhs;
            mVsync     = nvs;
        end
    endtask

    task automatic checkOutputs();
        checkValue("hsync", hsync, mHsync);
        checkValue("vsync", vsync, mVsync);
        checkValue("hBlank", hBlank, mHblank);
        checkValue("vBlank", vBlank, mVblank);
        checkValue("preVBlank", preVBlank, mSh0);
        checkValue("hostReady", hostReady, cen8 && mHdump % 2 == 1);
        // Line buffer words never fetched since power-up hold no known value.
        if (mPixelKnown) begin
            checkValue("pixel", pixel, mPixel);
            if (mPixel != 4'd0) activeChecks++;
        end
        if (vsync && !prevVsync) vsyncRises++;
        prevVsync = vsync;
    endtask

    // New stimulus for the cycle that starts at this rising edge.
    task automatic driveInputs();
        logic nextCen8;
        int   row;
        int   word;
        nextCen8 = !cen8;
        cen8      <= nextCen8;
        hostWrite <= 1'b0;
        // hostReady is high in this cycle only with cen8 and odd hdump.
        if (nextCen8 && mHdump % 2 == 1 && writeMode != 0) begin
            row  = -1;
            word = 0;
            if (writeMode == 1 && fillIndex < fillWords) begin
                row  = fillIndex / videoPkg::lineWords;
                word = fillIndex % videoPkg::lineWords;
                fillIndex++;
            end else if (writeMode == 2 && $urandom % 4 != 0) begin
                if (mFetching && $urandom % 2 == 0) begin
                    // Aim just behind, at or ahead of the next fetch.
                    row  = mVrender - videoPkg::vVisibleStart;
                    word = mWordIdx + int'($urandom % 3) - 1;
                    if (word < 0) word = 0;
                    if (word > videoPkg::lineWords - 1) word = videoPkg::lineWords - 1;
                    raceWrites++;
                end else begin
                    row  = $urandom % (videoPkg::vVisibleEnd - videoPkg::vVisibleStart + 1);
                    word = $urandom % videoPkg::lineWords;
                end
            end
            if (row >= 0) begin
                hostWrite <= 1'b1;
                hostAddr  <= videoPkg::vramAddrBits'(row * videoPkg::rowStride + word);
                hostData  <= 16'($urandom);
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        checkOutputs();
        advanceModel();
        @(posedge clk);
        driveInputs();
    endtask

    initial begin
        int cycles;
        int startRises;
        void'($urandom(32'hed9d_555f));
        cen8      = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostData  = '0;
        writeMode    = 0;
        fillIndex    = 0;
        activeChecks = 0;
        vsyncRises   = 0;
        raceWrites   = 0;
        prevVsync    = 1'b0;
        modelInReset = 1'b1;
        fillWords   = (videoPkg::vVisibleEnd - videoPkg::vVisibleStart + 1) * videoPkg::lineWords;
        frameClocks = 2 * videoPkg::hTotal * videoPkg::vTotal;
        for (int i = 0; i < 2**videoPkg::vramAddrBits; i++) begin
            ramKnown[i] = 1'b0;
        end
        for (int i = 0; i < videoPkg::lineWords; i++) begin
            bufKnown[0][i] = 1'b0;
            bufKnown[1][i] = 1'b0;
        end
        // The first edge already sees reset.
        resetModel();
        @(posedge clk);
        driveInputs();

        cycles = 0;
        while (modelInReset) begin
            stepCycle();
            cycles++;
            if (cycles > 64) reportFailure("reset was never released");
        end

        // Fill every visible row once, well ahead of the fetcher.
        writeMode = 1;
        cycles = 0;
        while (fillIndex < fillWords) begin
            stepCycle();
            cycles++;
            if (cycles > frameClocks) reportFailure("bitmap fill did not finish within a frame");
        end

        // Align to a frame, then two frames of random and racing writes.
        writeMode  = 2;
        startRises = vsyncRises;
        cycles     = 0;
        while (vsyncRises == startRises) begin
            stepCycle();
            cycles++;
            if (cycles > 2 * frameClocks) reportFailure("vsync never rose");
        end
        for (cycles = 0; cycles < 2 * frameClocks; cycles++) begin
            stepCycle();
        end

        if (activeChecks > 0 && raceWrites > 0 && vsyncRises >= 2) begin
            $display("All tests passed!");
            $finish;
        end else begin
            reportFailure("run ended without active pixels, racing writes or two frames");
        end
    end

endmodule

// File: videoTop.f
common/videoPkg.sv
timing/videoTiming.sv
logic/vramArbiter.sv
render/scanlineFetch.sv
render/linePlayback.sv
logic/videoTop.sv
test/clockGen.sv
test/videoTopTb.sv

// File: Bender.yml
package:
  name: videoTop

sources:
  - common/videoPkg.sv
  - timing/videoTiming.sv
  - logic/vramArbiter.sv
  - render/scanlineFetch.sv
  - render/linePlayback.sv
  - logic/videoTop.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/videoTopTb.sv
